//--- all.f
logic/traffic_pkg.sv
logic/lane_lfsr.sv
logic/pattern_gen.sv
logic/addr_seq.sv
logic/test_ctrl.sv
logic/readback_check.sv
logic/mem_traffic_gen.sv
verification/tb_mem_traffic_gen.sv

//--- logic/addr_seq.sv
module addr_seq #(
  parameter traffic_pkg::row_t  MAX_ROW  = 13'd3,
  parameter traffic_pkg::bank_t MAX_BANK = 2'd3,
  parameter traffic_pkg::col_t  MAX_COL  = 10'd16
) (
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic                   step,
  input  logic                   rewind,
  output traffic_pkg::mem_addr_t addr,
  output logic                   range_end
);

  // last burst of the range
  assign range_end = (addr.col == MAX_COL) &&
                     (addr.row == MAX_ROW) &&
                     (addr.bank == MAX_BANK);

  // ----------------------------------------------------------------------
  // column, then row, then bank
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      addr <= '0;
    end
    else if (rewind)
    begin
      addr <= '0;
    end
    else if (step)
    begin
      if (addr.col >= MAX_COL)
      begin
        addr.col <= '0;
        if (addr.row == MAX_ROW)
        begin
          addr.row <= '0;
          if (addr.bank == MAX_BANK)
          begin
            addr.bank <= '0;
          end
          else
          begin
            addr.bank <= addr.bank + 2'd1;
          end
        end
        else
        begin
          addr.row <= addr.row + 13'd1;
        end
      end
      else
      begin
        addr.col <= addr.col + traffic_pkg::COL_STEP;
      end
    end
  end

  // MAX_COL off the COL_STEP grid would skip range_end and never finish
  a_col_in_range: assert property (@(posedge clk) disable iff (!reset_n)
    addr.col <= MAX_COL);

endmodule

//--- logic/lane_lfsr.sv
module lane_lfsr #(
  parameter traffic_pkg::byte_t SEED = 8'd1
) (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               advance,
  input  logic               load,
  input  traffic_pkg::byte_t load_value,
  output traffic_pkg::byte_t value
);

  logic feedback;

  // x^8 + x^6 + x^5 + x^4 + 1
  assign feedback = value[7] ^ value[5] ^ value[4] ^ value[3];

  // load wins over advance, no advance means the lane pauses
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      value <= SEED;
    end
    else if (load)
    begin
      value <= load_value;
    end
    else if (advance)
    begin
      value <= {value[6:0], feedback};
    end
  end

endmodule

//--- logic/mem_traffic_gen.sv
module mem_traffic_gen #(
  parameter traffic_pkg::row_t  MAX_ROW  = 13'd3,
  parameter traffic_pkg::bank_t MAX_BANK = 2'd3,
  parameter traffic_pkg::col_t  MAX_COL  = 10'd16
) (
  input  logic                              clk,
  input  logic                              reset_n,
  input  logic                              ready,
  input  traffic_pkg::data_t                rdata,
  input  logic                              rdata_valid,
  output traffic_pkg::mem_addr_t            addr,
  output logic                              write_req,
  output logic                              read_req,
  output logic                              burst_begin,
  output traffic_pkg::data_t                wdata,
  output logic [traffic_pkg::NUM_LANES-1:0] pnf_per_byte,
  output logic                              pnf_persist,
  output logic                              test_complete,
  output logic [7:0]                        test_status
);

  logic range_end;
  logic addr_step;
  logic addr_rewind;
  logic pat_capture;
  logic pat_reload;
  logic write_beat;
  logic in_test;

  // bit 0 sequential test running, bit 7 pass done
  assign test_status = {test_complete, 6'b000000, in_test};

  test_ctrl test_ctrl_i (
    .clk           (clk),           .reset_n     (reset_n),
    .ready         (ready),         .rdata_valid (rdata_valid),
    .range_end     (range_end),     .write_req   (write_req),
    .read_req      (read_req),      .burst_begin (burst_begin),
    .addr_step     (addr_step),     .addr_rewind (addr_rewind),
    .pat_capture   (pat_capture),   .pat_reload  (pat_reload),
    .write_beat    (write_beat),    .in_test     (in_test),
    .test_complete (test_complete)
  );

  addr_seq #(.MAX_ROW (MAX_ROW), .MAX_BANK (MAX_BANK), .MAX_COL (MAX_COL)) addr_seq_i (
    .clk (clk), .reset_n (reset_n), .step (addr_step), .rewind (addr_rewind),
    .addr (addr), .range_end (range_end)
  );

  // the same word feeds the write bus and the read compare
  pattern_gen pattern_gen_i (
    .clk (clk), .reset_n (reset_n), .write_beat (write_beat), .read_beat (rdata_valid),
    .capture (pat_capture), .reload (pat_reload), .word (wdata)
  );

  readback_check readback_check_i (
    .clk (clk), .reset_n (reset_n), .rdata (rdata), .rdata_valid (rdata_valid),
    .expected (wdata), .pnf_per_byte (pnf_per_byte), .pnf_persist (pnf_persist)
  );

endmodule

//--- logic/pattern_gen.sv
module pattern_gen (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               write_beat,
  input  logic               read_beat,
  input  logic               capture,
  input  logic               reload,
  output traffic_pkg::data_t word
);

  localparam int LANE_W = $bits(traffic_pkg::byte_t);

  traffic_pkg::data_t reload_word;
  logic               lane_advance;

  // one step per word written or returned
  assign lane_advance = write_beat | read_beat;

  // ----------------------------------------------------------------------
  // byte lane generators
  // ----------------------------------------------------------------------
  for (genvar i = 0; i < traffic_pkg::NUM_LANES; i++)
  begin : g_lane
    lane_lfsr #(
      .SEED (traffic_pkg::LANE_SEED[i])
    ) lane_lfsr_i (
      .clk        (clk),
      .reset_n    (reset_n),
      .advance    (lane_advance),
      .load       (reload),
      .load_value (reload_word[i*LANE_W +: LANE_W]),
      .value      (word[i*LANE_W +: LANE_W])
    );
  end

  // ----------------------------------------------------------------------
  // start pattern of the current pass
  // ----------------------------------------------------------------------
  // taken before the first write so the read phase can replay it
  always_ff @(posedge clk)
  begin
    if (capture)
    begin
      reload_word <= word;
    end
  end

endmodule

//--- logic/readback_check.sv
module readback_check (
  input  logic                                clk,
  input  logic                                reset_n,
  input  traffic_pkg::data_t                  rdata,
  input  logic                                rdata_valid,
  input  traffic_pkg::data_t                  expected,
  output logic [traffic_pkg::NUM_LANES-1:0]   pnf_per_byte,
  output logic                                pnf_persist
);

  logic [traffic_pkg::NUM_LANES-1:0] compare;
  logic [traffic_pkg::NUM_LANES-1:0] compare_reg;
  logic [traffic_pkg::NUM_LANES-1:0] compare_valid;
  logic                              valid_d;
  logic [3:0]                        seen_pipe;

  // one comparator per byte lane
  always_comb
  begin
    for (int i = 0; i < traffic_pkg::NUM_LANES; i++)
    begin
      compare[i] = (rdata[i*8 +: 8] == expected[i*8 +: 8]);
    end
  end

  // ----------------------------------------------------------------------
  // compare pipeline and pass/fail flags
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      compare_reg   <= '1;
      compare_valid <= '1;
      pnf_per_byte  <= '1;
      valid_d       <= 1'b0;
      seen_pipe     <= '0;
      pnf_persist   <= 1'b0;
    end
    else
    begin
      compare_reg <= compare;
      valid_d     <= rdata_valid;
      if (valid_d)
        compare_valid <= compare_reg;
      // output stage for pin timing
      pnf_per_byte <= compare_valid;
      // first read data flag, aligned to pnf_per_byte by the shift
      seen_pipe <= {seen_pipe[2:0], seen_pipe[0] | rdata_valid};
      // sticky low after any failing lane
      pnf_persist <= seen_pipe[2] & (&pnf_per_byte) & (pnf_persist | ~seen_pipe[3]);
    end
  end

endmodule

//--- logic/test_ctrl.sv
module test_ctrl (
  input  logic clk,
  input  logic reset_n,
  input  logic ready,
  input  logic rdata_valid,
  input  logic range_end,
  output logic write_req,
  output logic read_req,
  output logic burst_begin,
  output logic addr_step,
  output logic addr_rewind,
  output logic pat_capture,
  output logic pat_reload,
  output logic write_beat,
  output logic in_test,
  output logic test_complete
);

  localparam traffic_pkg::count_t BURST_BEATS = traffic_pkg::count_t'(traffic_pkg::BURST_LEN);

  traffic_pkg::ctrl_state_e state;
  traffic_pkg::beat_t       beat_cnt;
  traffic_pkg::count_t      rd_outstanding;
  logic                     last_beat;
  logic                     read_xfer;

  // ----------------------------------------------------------------------
  // strobes decoded from the state
  // ----------------------------------------------------------------------
  assign write_req     = (state == traffic_pkg::WR_BURST) ||
                         (state == traffic_pkg::WR_BEAT) ||
                         (state == traffic_pkg::WR_LAST);
  assign read_req      = (state == traffic_pkg::RD_BURST);
  assign burst_begin   = (state == traffic_pkg::WR_BURST) || (state == traffic_pkg::RD_BURST);
  assign write_beat    = write_req & ready;
  assign read_xfer     = read_req & ready;
  assign last_beat     = (beat_cnt == traffic_pkg::BURST_LEN - 3'd1);

  // address moves once per burst and stays on the last one
  assign addr_step     = ((write_beat & last_beat) | read_xfer) & ~range_end;
  assign addr_rewind   = (state == traffic_pkg::REWIND) || (state == traffic_pkg::DONE);
  assign pat_capture   = (state == traffic_pkg::IDLE);
  assign pat_reload    = (state == traffic_pkg::REWIND);
  assign in_test       = (state != traffic_pkg::IDLE) && (state != traffic_pkg::DONE);
  assign test_complete = (state == traffic_pkg::DONE);

  // ----------------------------------------------------------------------
  // pass sequencer
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state <= traffic_pkg::IDLE;
    end
    else
    begin
      case (state)
        traffic_pkg::IDLE:
          state <= traffic_pkg::WR_BURST;
        traffic_pkg::WR_BURST:
          if (write_beat)
          begin
            if (last_beat && range_end)
              state <= traffic_pkg::REWIND;
            else if (range_end)
              state <= traffic_pkg::WR_LAST;
            else if (!last_beat)
              state <= traffic_pkg::WR_BEAT;
          end
        traffic_pkg::WR_BEAT:
          if (write_beat && last_beat)
            state <= traffic_pkg::WR_BURST;
        // remaining beats of the final burst
        traffic_pkg::WR_LAST:
          if (write_beat && last_beat)
            state <= traffic_pkg::REWIND;
        traffic_pkg::REWIND:
          state <= traffic_pkg::RD_BURST;
        traffic_pkg::RD_BURST:
          if (read_xfer && range_end)
            state <= traffic_pkg::RD_DRAIN;
        traffic_pkg::RD_DRAIN:
          if (rd_outstanding == '0)
            state <= traffic_pkg::DONE;
        default:
          state <= traffic_pkg::IDLE;
      endcase
    end
  end

  // write beat index within the burst
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      beat_cnt <= '0;
    else if (write_beat)
      beat_cnt <= last_beat ? '0 : beat_cnt + 3'd1;
  end

  // read beats requested but not yet returned
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      rd_outstanding <= '0;
    end
    else
    begin
      case ({read_xfer, rdata_valid})
        2'b10:   rd_outstanding <= rd_outstanding + BURST_BEATS;
        2'b11:   rd_outstanding <= rd_outstanding + BURST_BEATS - 8'd1;
        2'b01:   rd_outstanding <= rd_outstanding - 8'd1;
        default: rd_outstanding <= rd_outstanding;
      endcase
    end
  end

  // a stalled request waits for ready
  a_req_held: assert property (@(posedge clk) disable iff (!reset_n)
    (write_req || read_req) && !ready |=> $stable({write_req, read_req, burst_begin, beat_cnt}));

  // the memory only returns what was asked for
  a_no_stray_data: assert property (@(posedge clk) disable iff (!reset_n)
    rdata_valid |-> (rd_outstanding != '0));

endmodule

//--- logic/traffic_pkg.sv
package traffic_pkg;

  // ----------------------------------------------------------------------
  // local port widths
  // ----------------------------------------------------------------------
  typedef logic [31:0] data_t;
  typedef logic [7:0]  byte_t;
  typedef logic [12:0] row_t;
  typedef logic [1:0]  bank_t;
  typedef logic [9:0]  col_t;

  // outstanding read beats
  typedef logic [7:0]  count_t;

  // beat index inside one burst
  typedef logic [2:0]  beat_t;

  // address as seen by the memory controller
  typedef struct packed {
    row_t  row;
    bank_t bank;
    col_t  col;
  } mem_addr_t;

  // ----------------------------------------------------------------------
  // traffic shape
  // ----------------------------------------------------------------------
  localparam int    NUM_LANES = 4;
  localparam beat_t BURST_LEN = 3'd2;

  // two beats of a half-rate word per burst
  localparam col_t  COL_STEP  = 10'd4;

  // start value of each byte lane lfsr
  localparam byte_t LANE_SEED [NUM_LANES] = '{8'd1, 8'd11, 8'd21, 8'd31};

  // pass sequencer states
  typedef enum logic [2:0] {
    IDLE,
    WR_BURST,
    WR_BEAT,
    WR_LAST,
    REWIND,
    RD_BURST,
    RD_DRAIN,
    DONE
  } ctrl_state_e;

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the traffic generator testbench with verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_mem_traffic_gen \
  --Mdir "$build_dir" -o tb_sim \
  -f all.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$build_dir/tb_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "TB PASSED" "$log_file"; then
  echo "result: pass"
  exit 0
fi
echo "result: fail"
exit 1

//--- verification/tb_mem_traffic_gen.sv
module tb_mem_traffic_gen;

  localparam traffic_pkg::row_t  MAX_ROW  = 13'd3;
  localparam traffic_pkg::bank_t MAX_BANK = 2'd3;
  localparam traffic_pkg::col_t  MAX_COL  = 10'd16;

  localparam int COLS         = int'(MAX_COL) / 4 + 1;
  localparam int ROWS         = int'(MAX_ROW) + 1;
  localparam int NUM_BURSTS   = COLS * ROWS * (int'(MAX_BANK) + 1);
  localparam int BURST_LEN    = 2;
  localparam int NUM_PASSES   = 3;
  localparam int PASS_TIMEOUT = 3000;
  localparam int BAD_BEAT     = 57;

  logic                   clk;
  logic                   reset_n;
  logic                   ready;
  traffic_pkg::data_t     rdata;
  logic                   rdata_valid;
  traffic_pkg::mem_addr_t addr;
  logic                   write_req;
  logic                   read_req;
  logic                   burst_begin;
  traffic_pkg::data_t     wdata;
  logic [3:0]             pnf_per_byte;
  logic                   pnf_persist;
  logic                   test_complete;
  logic [7:0]             test_status;

  // memory responder, lfsr reference and compare model
  traffic_pkg::data_t mem_model [int];
  int                 rd_key_q [$];
  int                 rd_due_q [$];
  logic [3:0]         beat_mask [int];
  logic [7:0]         ref_lane [4];
  logic [31:0]        rng_state;
  traffic_pkg::data_t rd_word;
  logic [3:0]         exp_pnf = 4'hf;
  logic               exp_persist = 1'b0;
  logic               prev_wr_stall = 1'b0;
  logic               prev_rd_stall = 1'b0;
  logic               prev_complete = 1'b0;
  logic               bad_sent = 1'b0;
  int                 cyc = 0;
  int                 first_valid = -1;
  int                 last_done = 0;
  int                 pass_count = 0;
  int                 wr_burst = 0;
  int                 wr_beat = 0;
  int                 rd_burst = 0;
  int                 rd_beats = 0;

  mem_traffic_gen #(
    .MAX_ROW  (MAX_ROW),
    .MAX_BANK (MAX_BANK),
    .MAX_COL  (MAX_COL)
  ) mem_traffic_gen_i (
    .clk           (clk),           .reset_n      (reset_n),
    .ready         (ready),         .rdata        (rdata),
    .rdata_valid   (rdata_valid),   .addr         (addr),
    .write_req     (write_req),     .read_req     (read_req),
    .burst_begin   (burst_begin),   .wdata        (wdata),
    .pnf_per_byte  (pnf_per_byte),  .pnf_persist  (pnf_persist),
    .test_complete (test_complete), .test_status  (test_status)
  );

  always #2 clk = ~clk;

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // burst idx of a phase, column first, then row, then bank
  function automatic traffic_pkg::mem_addr_t burst_addr(input int idx);
    traffic_pkg::mem_addr_t a;
    a.col  = traffic_pkg::col_t'((idx % COLS) * 4);
    a.row  = traffic_pkg::row_t'((idx / COLS) % ROWS);
    a.bank = traffic_pkg::bank_t'(idx / (COLS * ROWS));
    return a;
  endfunction

  function automatic traffic_pkg::data_t ref_word();
    return {ref_lane[3], ref_lane[2], ref_lane[1], ref_lane[0]};
  endfunction

  // taps 8, 6, 5, 4, shifting toward the msb
  task automatic ref_advance();
    for (int i = 0; i < 4; i++)
      ref_lane[i] = {ref_lane[i][6:0],
                     ref_lane[i][7] ^ ref_lane[i][5] ^ ref_lane[i][4] ^ ref_lane[i][3]};
  endtask

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic compare_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
    if (actual !== expected)
      fail_run($sformatf("ERR t=%0t %s: got %0h, expected %0h", $time, name, actual, expected));
  endtask

  // ----------------------------------------------------------------------
  // memory side, driven just after the rising edge
  // ----------------------------------------------------------------------
  task automatic drive_inputs();
    logic [31:0] r;
    int          lane;
    int          key;
    r           = next_random();
    ready       = (r[31:30] != 2'b00);
    rdata       = next_random();
    rdata_valid = 1'b0;
    if (rd_due_q.size() > 0 && rd_due_q[0] <= cyc)
    begin
      void'(rd_due_q.pop_front());
      key            = rd_key_q.pop_front();
      rd_word        = mem_model[key];
      rdata          = rd_word;
      rdata_valid    = 1'b1;
      beat_mask[cyc] = 4'hf;
      if (first_valid < 0)
        first_valid = cyc;
      // one bad byte in the third pass
      if (pass_count == NUM_PASSES - 1 && rd_beats == BAD_BEAT)
      begin
        lane           = int'(r[17:16]);
        rdata          = rd_word ^ (32'hff << (8 * lane));
        beat_mask[cyc] = 4'hf ^ (4'b0001 << lane);
        bad_sent       = 1'b1;
      end
      rd_beats++;
    end
  endtask

  // ----------------------------------------------------------------------
  // checks at the falling edge, where everything has settled
  // ----------------------------------------------------------------------
  task automatic sample_outputs();
    int lat;
    if (cyc < 2)
      compare_value("write_req after reset", 32'(write_req), 32'(cyc));
    compare_value("write_req & read_req", 32'(write_req & read_req), 32'd0);
    compare_value("test_status[7]", 32'(test_status[7]), 32'(test_complete));
    compare_value("test_status[6:1]", 32'(test_status[6:1]), 32'd0);
    if (prev_wr_stall)
      compare_value("write_req held", 32'(write_req), 32'd1);
    if (prev_rd_stall)
      compare_value("read_req held", 32'(read_req), 32'd1);
    if (write_req)
    begin
      compare_value("write_req phase", 32'(wr_burst < NUM_BURSTS && rd_burst == 0), 32'd1);
      compare_value("test_status[0]", 32'(test_status[0]), 32'd1);
      compare_value("addr", 32'(addr), 32'(burst_addr(wr_burst)));
      compare_value("burst_begin", 32'(burst_begin), 32'(wr_beat == 0));
      compare_value("wdata", wdata, ref_word());
      if (ready)
      begin
        mem_model[int'(addr) + wr_beat] = wdata;
        ref_advance();
        wr_beat++;
        if (wr_beat == BURST_LEN)
        begin
          wr_beat = 0;
          wr_burst++;
        end
      end
    end
    else if (read_req)
    begin
      compare_value("read_req phase", 32'(wr_burst == NUM_BURSTS && rd_burst < NUM_BURSTS),
                    32'd1);
      compare_value("test_status[0]", 32'(test_status[0]), 32'd1);
      compare_value("addr", 32'(addr), 32'(burst_addr(rd_burst)));
      compare_value("burst_begin", 32'(burst_begin), 32'd1);
      if (ready)
      begin
        lat = int'(next_random() >> 24) % 6;
        for (int b = 0; b < BURST_LEN; b++)
        begin
          if (!mem_model.exists(int'(addr) + b))
            fail_run("read request for an address that was never written");
          rd_key_q.push_back(int'(addr) + b);
          rd_due_q.push_back(cyc + 1 + lat + b);
        end
        rd_burst++;
      end
    end
    else
      compare_value("burst_begin", 32'(burst_begin), 32'd0);

    // the compare word during reads is the replayed write data
    if (rdata_valid)
      compare_value("wdata on read beat", wdata, rd_word);
    if (beat_mask.exists(cyc - 3))
      exp_pnf = beat_mask[cyc - 3];
    compare_value("pnf_per_byte", 32'(pnf_per_byte), 32'(exp_pnf));
    compare_value("pnf_persist", 32'(pnf_persist), 32'(exp_persist));
    // rises after the first checked beat, low for good after a miss
    exp_persist = (first_valid >= 0) && (cyc >= first_valid + 3) && (exp_pnf == 4'hf) &&
                  (exp_persist || cyc == first_valid + 3);

    if (test_complete)
    begin
      compare_value("test_complete length", 32'(prev_complete), 32'd0);
      compare_value("test_status[0]", 32'(test_status[0]), 32'd0);
      compare_value("read beats per pass", 32'(rd_beats), 32'(NUM_BURSTS * BURST_LEN));
      pass_count++;
      last_done = cyc;
      wr_burst  = 0;
      rd_burst  = 0;
      rd_beats  = 0;
    end
    prev_wr_stall = write_req & ~ready;
    prev_rd_stall = read_req & ~ready;
    prev_complete = test_complete;
  endtask

  task automatic run_cycle();
    @(posedge clk);
    #1;
    reset_n = 1'b1;
    drive_inputs();
    @(negedge clk);
    sample_outputs();
    cyc++;
  endtask

  initial
  begin
    clk         = 1'b0;
    reset_n     = 1'b0;
    ready       = 1'b0;
    rdata       = '0;
    rdata_valid = 1'b0;
    rng_state   = 32'h9bf9;
    ref_lane    = '{8'd1, 8'd11, 8'd21, 8'd31};

    repeat (8)
    begin
      @(negedge clk);
      compare_value("outputs in reset", 32'({write_req, read_req, burst_begin, test_complete,
                                             pnf_persist, pnf_per_byte}), 32'h00f);
    end

    while (pass_count < NUM_PASSES)
    begin
      run_cycle();
      if (cyc - last_done > PASS_TIMEOUT)
        fail_run($sformatf("timeout: pass %0d did not complete within %0d cycles",
                           pass_count + 1, PASS_TIMEOUT));
    end

    // a few more cycles into the next pass
    repeat (6)
      run_cycle();

    compare_value("bad byte sent", 32'(bad_sent), 32'd1);
    compare_value("pnf_persist after bad byte", 32'(pnf_persist), 32'd0);
    $display("TB PASSED");
    $finish;
  end

endmodule
